//--- build.f
core_pkg.sv
fetch_pc.sv
inst_decode.sv
stage_reg.sv
exec_unit.sv
retire_log.sv
frontend_top.sv
frontend_chk.sv
frontend_tb.sv

//--- core_pkg.sv
package core_pkg;

	//////////////////////////////////////////////////
	// default widths
	//////////////////////////////////////////////////

	parameter int addr_w = 64;  // byte address width
	parameter int inst_w = 32;  // one instruction slot

	// opcode lives in the top nibble of each slot
	typedef enum logic [3:0] {
		op_nop  = 4'h0,
		op_addi = 4'h1,  // acc += sext(imm)
		op_jump = 4'h2,  // pc-relative, offset in pairs
		op_bnz  = 4'h3,  // same offset rule, taken when acc != 0
		op_halt = 4'hf   // stop fetch and retirement
	} opcode_t;

	//////////////////////////////////////////////////
	// pipeline payloads
	//////////////////////////////////////////////////

	// fetched pair, slot 0 is the low word of the memory data
	typedef struct packed {
		logic [addr_w-1:0] pc;     // pair address, 8-byte aligned
		logic [inst_w-1:0] inst0;
		logic [inst_w-1:0] inst1;
		logic              valid;
	} inst_pair_t;

	typedef struct packed {
		opcode_t           opcode;
		logic [15:0]       imm;       // raw, sign extended in execute
		logic [addr_w-1:0] pc;        // address of this slot
		logic              is_branch; // jump or bnz
		logic [inst_w-1:0] raw;
	} decoded_slot_t;

	typedef struct packed {
		decoded_slot_t slot0;
		decoded_slot_t slot1;
		logic          valid;
	} decoded_pair_t;

	// one-cycle pulse from execute back to fetch
	typedef struct packed {
		logic              taken;
		logic [addr_w-1:0] target;
	} redirect_t;

	typedef struct packed {
		logic [1:0]        valid;  // bit n set when slot n retired
		logic [addr_w-1:0] pc0;
		logic [addr_w-1:0] pc1;
		logic [inst_w-1:0] inst0;
		logic [inst_w-1:0] inst1;
	} retire_t;

endpackage

//--- exec_unit.sv
module exec_unit
	import core_pkg::*;
(
	input  logic          clock,
	input  logic          reset,
	input  decoded_pair_t pair,        // pair held in the stage register
	input  logic          pair_valid,
	output redirect_t     redirect,    // combinational, one cycle wide
	output retire_t       retire,      // slots that complete this cycle
	output logic [31:0]   acc,
	output logic          halted
);

	//////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////

	function automatic logic [31:0] imm_sext(input logic [15:0] imm);
		imm_sext = {{16{imm[15]}}, imm};
	endfunction

	// pair boundary of the slot plus imm pairs
	function automatic logic [addr_w-1:0] branch_target(input decoded_slot_t s);
		logic [addr_w-1:0] base;
		logic [addr_w-1:0] offset;
		base   = {s.pc[addr_w-1:3], 3'b000};
		offset = {{(addr_w-19){s.imm[15]}}, s.imm, 3'b000};  // imm * 8
		branch_target = base + offset;
	endfunction

	function automatic logic slot_taken(input decoded_slot_t s, input logic [31:0] a);
		slot_taken = s.is_branch && ((s.opcode == op_jump) || (a != 32'd0));
	endfunction

	//////////////////////////////////////////////////
	// slot evaluation
	//////////////////////////////////////////////////

	logic [31:0] acc_q;
	logic [31:0] acc_mid;   // acc after slot 0
	logic [31:0] acc_next;  // acc after both slots
	logic        halted_q;
	logic        live;      // pair really executes
	logic        take0, take1;
	logic        halt0, halt1;

	always_comb
	begin
		live     = pair_valid && pair.valid && !halted_q;  // nothing runs after halt
		acc_mid  = acc_q;
		acc_next = acc_q;
		take0    = 1'b0;
		take1    = 1'b0;
		halt0    = 1'b0;
		halt1    = 1'b0;

		retire.valid = 2'b00;
		retire.pc0   = pair.slot0.pc;
		retire.pc1   = pair.slot1.pc;
		retire.inst0 = pair.slot0.raw;
		retire.inst1 = pair.slot1.raw;

		if (live)
		begin
			// slot 0 always retires when the pair is live
			retire.valid[0] = 1'b1;
			if (pair.slot0.opcode == op_addi)
				acc_mid = acc_q + imm_sext(pair.slot0.imm);
			take0    = slot_taken(pair.slot0, acc_q);
			halt0    = (pair.slot0.opcode == op_halt);
			acc_next = acc_mid;

			// a taken branch or halt in slot 0 squashes slot 1
			if (!take0 && !halt0)
			begin
				retire.valid[1] = 1'b1;
				if (pair.slot1.opcode == op_addi)
					acc_next = acc_mid + imm_sext(pair.slot1.imm);
				take1 = slot_taken(pair.slot1, acc_mid);  // sees slot 0 addi
				halt1 = (pair.slot1.opcode == op_halt);
			end
		end

		redirect.taken  = take0 || take1;
		redirect.target = take0 ? branch_target(pair.slot0) : branch_target(pair.slot1);
	end

	//////////////////////////////////////////////////
	// architectural state
	//////////////////////////////////////////////////

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			acc_q    <= 32'd0;
			halted_q <= 1'b0;
		end
		else
		begin
			acc_q    <= acc_next;
			halted_q <= halted_q || halt0 || halt1;  // sticky until reset
		end
	end

	assign acc    = acc_q;
	assign halted = halted_q;

endmodule

//--- fetch_pc.sv
module fetch_pc
	import core_pkg::*;
#(
	parameter int addr_w = core_pkg::addr_w
)
(
	input  logic              clock,
	input  logic              reset,
	input  logic [3:0]        stall_in,    // rs, rob, rat, mem hazard
	input  logic              halted,      // from execute, stops fetch for good
	input  redirect_t         redirect,
	input  logic [63:0]       imem_data,   // two slots per access
	input  logic              imem_valid,
	output logic [addr_w-1:0] imem_addr,
	output inst_pair_t        pair         // registered fetch output
);

	//////////////////////////////////////////////////
	// pc and next-pc choice
	//////////////////////////////////////////////////

	logic [addr_w-1:0] pc_q;       // pc being fetched this cycle
	logic [addr_w-1:0] pc_next;
	logic              stall;      // any back-end stall
	inst_pair_t        pair_next;  // what the output register loads

	assign stall = |stall_in;

	// memory is addressed by pair, the low bits never reach it
	assign imem_addr = {pc_q[addr_w-1:3], 3'b000};

	always_comb
	begin
		// payload follows the memory, only valid is decided below
		pair_next.pc    = pc_q;
		pair_next.inst0 = imem_data[31:0];   // slot 0, low word
		pair_next.inst1 = imem_data[63:32];  // slot 1
		pair_next.valid = 1'b0;

		if (redirect.taken)
		begin
			// redirect wins over every stall, else the branch would be lost
			pc_next = redirect.target;
			// data fetched this cycle is wrong path, drop it
		end
		else if (stall || !imem_valid || halted)
		begin
			pc_next = pc_q;  // hold and insert a bubble
		end
		else
		begin
			pc_next         = pc_q + 8;  // next pair
			pair_next.valid = 1'b1;
		end
	end

	//////////////////////////////////////////////////
	// registers
	//////////////////////////////////////////////////

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			pc_q <= '0;  // program starts at 0
		end
		else
		begin
			pc_q <= pc_next;
		end
	end

	// only the valid bit is cleared, instruction words are payload
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			pair.valid <= 1'b0;
		end
		else
		begin
			pair <= pair_next;
		end
	end

endmodule

//--- frontend_chk.sv
module frontend_chk
	import core_pkg::*;
#(
	parameter int addr_w = core_pkg::addr_w
)
(
	input logic              clock,
	input logic              reset,
	input logic [addr_w-1:0] imem_addr,
	input redirect_t         redirect,  // execute back to fetch
	input retire_t           retired,
	input logic              halted
);
	timeunit 1ns;
	timeprecision 1ps;

	// the flush after a redirect leaves execute empty for a cycle
	redirect_pulse: assert property (@(posedge clock) disable iff (reset)
		redirect.taken |=> !redirect.taken)
		else $error("redirect taken high in two consecutive cycles");

	// fetch loads the redirect target, which must sit on a pair boundary
	pair_aligned: assert property (@(posedge clock) disable iff (reset)
		redirect.taken |=> imem_addr == $past(redirect.target))
		else $error("imem_addr did not load the pair-aligned redirect target");

	// one cycle after reset is seen, outputs hold their reset values
	reset_state: assert property (@(posedge clock)
		reset |=> (retired.valid == 2'b00) && !halted)
		else $error("retired valid or halted set right after reset");

	halt_sticky: assert property (@(posedge clock) disable iff (reset)
		halted |=> halted)
		else $error("halted fell without reset");  // only reset clears it

endmodule

bind frontend_top frontend_chk #(.addr_w(addr_w)) u_chk (
	.clock     (clock),
	.reset     (reset),
	.imem_addr (imem_addr),
	.redirect  (redirect),
	.retired   (retired),
	.halted    (halted)
);

//--- frontend_tb.sv
module frontend_tb
	import core_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	//////////////////////////////////////////////////
	// program table, one row per run
	//////////////////////////////////////////////////

	localparam int n_rows = 6;
	localparam logic [31:0] prog_tab [n_rows][8] = '{
		'{32'h1000_0005, 32'h1000_0003, 32'h1000_fffe, 32'h1000_0010,   // straight line
		  32'h7000_0001, 32'h1000_0001, 32'hf000_0000, 32'h0000_0000},
		'{32'h1000_0001, 32'h1000_0002, 32'h2000_0002, 32'h1000_0100,   // jump skips slot 1
		  32'h1000_0200, 32'h1000_0400, 32'h1000_0008, 32'hf000_0000},
		'{32'h1000_0000, 32'h3000_0002, 32'h1000_0003, 32'h3000_0002,   // bnz fall and take
		  32'h1000_0100, 32'h1000_0200, 32'h1000_0007, 32'hf000_0000},
		'{32'h1000_0003, 32'h0000_0000, 32'h1000_ffff, 32'h3000_0000,   // countdown loop
		  32'h1000_0009, 32'hf000_0000, 32'h0000_0000, 32'h0000_0000},
		'{32'h1000_0002, 32'h2000_0002, 32'h1000_0050, 32'h1000_0060,   // slot 1 jump
		  32'h1000_fffe, 32'h3000_0005, 32'h1000_0004, 32'hf000_0000},
		'{32'h1000_0005, 32'h1000_0003, 32'h1000_fffe, 32'h1000_0010,   // row 0 under stalls
		  32'h7000_0001, 32'h1000_0001, 32'hf000_0000, 32'h0000_0000}
	};
	localparam int prog_len [n_rows]  = '{7, 8, 8, 6, 8, 7};
	localparam int stall_pct [n_rows] = '{0, 0, 10, 30, 40, 25};  // chance of a stall per cycle
	localparam int drop_pct [n_rows]  = '{0, 0, 10, 20, 30, 25};  // chance imem_valid is low

	logic        clock;
	logic        reset;
	logic [63:0] imem_addr;
	logic [63:0] imem_data;
	logic        imem_valid;
	logic        rs_stall, rob_stall, rat_stall, mem_hazard_stall;
	retire_t     retired;
	logic [15:0] retire_count;
	logic [31:0] acc;
	logic        halted;

	int          seed = 16833;
	int          cur_row;
	int          ptr;        // next entry of exp_pcs to retire
	int          exp_pcs[$];
	logic [31:0] exp_acc;

	frontend_top #(.addr_w(64)) dut (
		.clock (clock), .reset (reset),
		.imem_addr (imem_addr), .imem_data (imem_data), .imem_valid (imem_valid),
		.rs_stall (rs_stall), .rob_stall (rob_stall),
		.rat_stall (rat_stall), .mem_hazard_stall (mem_hazard_stall),
		.retired (retired), .retire_count (retire_count), .acc (acc), .halted (halted)
	);

	initial
	begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	//////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////

	function automatic logic [31:0] prog_word(input int row, input int idx);
		if (idx < 0 || idx >= prog_len[row])
			return 32'hf000_0000;  // halt past the end
		return prog_tab[row][idx];
	endfunction

	function automatic int rand_pct();
		return ($random(seed) & 32'h7fff_ffff) % 100;
	endfunction

	// 40 cycles per word, stretched by how often the row starves fetch
	function automatic int watchdog_cycles();
		int total;
		total = 0;
		for (int r = 0; r < n_rows; r++)
			total = total + 40 * prog_len[r] * (1 + (stall_pct[r] + drop_pct[r]) / 10) + 20;
		return total;
	endfunction

	task automatic stop_on_failure();
		$display("Done: errors found");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		assert (got === exp)
		else
		begin
			$display("CHECK FAILED at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
			stop_on_failure();
		end
	endtask

	// retired slot must be the next pc of the model and carry that program word
	task automatic check_retired(input logic [63:0] pc, input logic [31:0] inst);
		assert (ptr < exp_pcs.size())
		else
		begin
			$display("an instruction retired after the program should have halted");
			stop_on_failure();
		end
		check_value("retired pc", pc, 64'(exp_pcs[ptr]));
		check_value("retired inst", 64'(inst), 64'(prog_word(cur_row, exp_pcs[ptr] / 4)));
		ptr++;
	endtask

	// architectural model, one instruction at a time from pc 0
	task automatic run_model(input int row);
		int          pc;
		int          imm;
		logic [31:0] word;
		bit          done;
		pc      = 0;
		exp_acc = 32'd0;
		done    = 1'b0;
		exp_pcs.delete();
		while (!done && exp_pcs.size() < 64)
		begin
			word = prog_word(row, pc / 4);
			imm  = int'($signed(word[15:0]));
			exp_pcs.push_back(pc);
			case (word[31:28])
				4'h1:
				begin
					exp_acc = exp_acc + 32'(imm);
					pc      = pc + 4;
				end
				4'h2: pc = (pc / 8 + imm) * 8;  // offset counted in pairs
				4'h3: pc = (exp_acc != 32'd0) ? (pc / 8 + imm) * 8 : pc + 4;
				4'hf: done = 1'b1;  // halt retires too
				default: pc = pc + 4;  // nop and unknown opcodes
			endcase
		end
	endtask

	// one cycle: sample outputs, then drive inputs, both on the falling edge
	task automatic step_cycle(input bit random_on);
		int idx;
		bit stall_hit;
		int which;
		@(negedge clock);
		if (!reset)
		begin
			if (retired.valid[0]) check_retired(retired.pc0, retired.inst0);
			if (retired.valid[1]) check_retired(retired.pc1, retired.inst1);
		end
		idx       = int'(imem_addr[31:2]);
		imem_data = {prog_word(cur_row, idx + 1), prog_word(cur_row, idx)};  // slot 0 low
		stall_hit = random_on && (rand_pct() < stall_pct[cur_row]);
		which     = rand_pct() % 4;  // one stall source at a time
		rs_stall         = stall_hit && (which == 0);
		rob_stall        = stall_hit && (which == 1);
		rat_stall        = stall_hit && (which == 2);
		mem_hazard_stall = stall_hit && (which == 3);
		imem_valid       = !random_on || (rand_pct() >= drop_pct[cur_row]);
	endtask

	//////////////////////////////////////////////////
	// main sequence and watchdog
	//////////////////////////////////////////////////

	initial
	begin
		reset            = 1'b1;
		imem_data        = 64'd0;
		imem_valid       = 1'b1;
		rs_stall         = 1'b0;
		rob_stall        = 1'b0;
		rat_stall        = 1'b0;
		mem_hazard_stall = 1'b0;
		ptr              = 0;
		for (int row = 0; row < n_rows; row++)
		begin
			cur_row = row;
			run_model(row);
			reset = 1'b1;
			ptr   = 0;
			repeat (10) step_cycle(1'b0);
			check_value("retired.valid after reset", 64'(retired.valid), 64'd0);
			check_value("acc after reset", 64'(acc), 64'd0);
			check_value("halted after reset", 64'(halted), 64'd0);
			check_value("retire_count after reset", 64'(retire_count), 64'd0);
			reset = 1'b0;
			while (!halted)
				step_cycle(1'b1);
			repeat (4) step_cycle(1'b1);  // nothing more may retire
			check_value("halted", 64'(halted), 64'd1);
			check_value("acc", 64'(acc), 64'(exp_acc));
			check_value("retire_count", 64'(retire_count), 64'(exp_pcs.size()));
			check_value("retired pcs seen", 64'(ptr), 64'(exp_pcs.size()));
		end
		$display("Done: no errors");
		$finish;
	end

	initial
	begin
		repeat (watchdog_cycles()) @(posedge clock);
		$display("watchdog expired before every program halted");
		stop_on_failure();
	end

endmodule

//--- frontend_top.sv
module frontend_top
	import core_pkg::*;
#(
	parameter int addr_w = core_pkg::addr_w
)
(
	input  logic              clock,
	input  logic              reset,
	output logic [addr_w-1:0] imem_addr,
	input  logic [63:0]       imem_data,
	input  logic              imem_valid,
	input  logic              rs_stall,
	input  logic              rob_stall,
	input  logic              rat_stall,
	input  logic              mem_hazard_stall,
	output retire_t           retired,
	output logic [15:0]       retire_count,
	output logic [31:0]       acc,
	output logic              halted
);

	//////////////////////////////////////////////////
	// interconnect
	//////////////////////////////////////////////////

	inst_pair_t    fetch_pair;  // fetch register output
	decoded_slot_t dec0, dec1;
	decoded_pair_t dec_pair;    // into the stage register
	decoded_pair_t ex_pair;     // held for execute
	logic          ex_valid;
	redirect_t     redirect;
	retire_t       retire;

	fetch_pc #(.addr_w(addr_w)) u_fetch (
		.clock      (clock),
		.reset      (reset),
		.stall_in   ({mem_hazard_stall, rat_stall, rob_stall, rs_stall}),
		.halted     (halted),
		.redirect   (redirect),
		.imem_data  (imem_data),
		.imem_valid (imem_valid),
		.imem_addr  (imem_addr),
		.pair       (fetch_pair)
	);

	// pairs are aligned so slot 1 sits at pair pc + 4
	inst_decode u_dec0 (.inst(fetch_pair.inst0), .pc(fetch_pair.pc), .slot(dec0));
	inst_decode u_dec1 (
		.inst (fetch_pair.inst1),
		.pc   ({fetch_pair.pc[addr_w-1:3], 3'b100}),
		.slot (dec1)
	);

	assign dec_pair = '{slot0: dec0, slot1: dec1, valid: fetch_pair.valid};

	// a redirect throws away the pair leaving decode
	stage_reg #(.payload_t(decoded_pair_t)) u_stage (
		.clock   (clock),
		.reset   (reset),
		.flush   (redirect.taken),
		.d       (dec_pair),
		.d_valid (fetch_pair.valid),
		.q       (ex_pair),
		.q_valid (ex_valid)
	);

	exec_unit u_exec (
		.clock      (clock),
		.reset      (reset),
		.pair       (ex_pair),
		.pair_valid (ex_valid),
		.redirect   (redirect),
		.retire     (retire),
		.acc        (acc),
		.halted     (halted)
	);

	retire_log u_retire (
		.clock        (clock),
		.reset        (reset),
		.retire       (retire),
		.retired_out  (retired),
		.retire_count (retire_count)
	);

endmodule

//--- inst_decode.sv
module inst_decode
	import core_pkg::*;
(
	input  logic [inst_w-1:0] inst,  // one slot of the fetched pair
	input  logic [addr_w-1:0] pc,    // address of this slot
	output decoded_slot_t     slot
);

	//////////////////////////////////////////////////
	// field extraction
	//////////////////////////////////////////////////

	logic [3:0] op_field;  // bits 31..28
	opcode_t    opcode;    // legal opcode after mapping

	assign op_field = inst[31:28];

	// anything outside the small set runs as a nop
	always_comb
	begin
		case (op_field)
			op_addi:
			begin
				opcode = op_addi;
			end
			op_jump:
			begin
				opcode = op_jump;
			end
			op_bnz:
			begin
				opcode = op_bnz;
			end
			op_halt:
			begin
				opcode = op_halt;
			end
			default:
			begin
				opcode = op_nop;  // includes 4'h0
			end
		endcase
	end

	//////////////////////////////////////////////////
	// decoded slot
	//////////////////////////////////////////////////

	always_comb
	begin
		slot.opcode    = opcode;
		slot.imm       = inst[15:0];  // sign extension happens in execute
		slot.pc        = pc;
		slot.is_branch = (opcode == op_jump) || (opcode == op_bnz);
		slot.raw       = inst;  // kept for the retire log
	end

endmodule

//--- retire_log.sv
module retire_log
	import core_pkg::*;
(
	input  logic        clock,
	input  logic        reset,
	input  retire_t     retire,        // from execute, combinational
	output retire_t     retired_out,   // registered copy for observation
	output logic [15:0] retire_count   // total slots retired since reset
);

	//////////////////////////////////////////////////
	// retired slot register
	//////////////////////////////////////////////////

	// valid bits cleared on reset, pcs and words are payload
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			retired_out.valid <= 2'b00;
		end
		else
		begin
			retired_out <= retire;
		end
	end

	//////////////////////////////////////////////////
	// retire counter
	//////////////////////////////////////////////////

	logic [15:0] count_q;
	logic [15:0] slots_now;  // 0, 1 or 2 this cycle

	assign slots_now = {15'd0, retire.valid[0]} + {15'd0, retire.valid[1]};

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			count_q <= 16'd0;
		end
		else
		begin
			count_q <= count_q + slots_now;  // wraps, long runs only
		end
	end

	assign retire_count = count_q;

endmodule

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f build.f --top-module frontend_tb -Mdir obj_dir -o frontend_sim

./obj_dir/frontend_sim | tee sim.log

if grep -q "Done: no errors" sim.log; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed"
	exit 1
fi

//--- stage_reg.sv
module stage_reg
#(
	parameter type payload_t = logic
)
(
	input  logic     clock,
	input  logic     reset,
	input  logic     flush,    // discard what is arriving this cycle
	input  payload_t d,
	input  logic     d_valid,
	output payload_t q,
	output logic     q_valid
);

	// valid is control, cleared by reset or flush
	always_ff @(posedge clock)
	begin
		if (reset || flush)
		begin
			q_valid <= 1'b0;
		end
		else
		begin
			q_valid <= d_valid;
		end
	end

	// payload only moves on a live entry, holds otherwise
	always_ff @(posedge clock)
	begin
		if (d_valid && !flush)
		begin
			q <= d;
		end
	end

endmodule
